/* icache_testdata.txt */
# Columns: op address word err beats. op is F for fetch or I for invalidate
# word and err are the expected response, beats the bus transfers started (8 = none or a line)
# First fetch misses mid line, refill from the line base
F 00000108 FFFFFEF7 0 4
# Same line hits
F 00000100 FFFFFEFF 0 0
F 00000104 FFFFFEFB 0 0
F 0000010C FFFFFEF3 0 0
# Three lines in set 4
F 00000040 FFFFFFBF 0 4
F 00000240 FFFFFDBF 0 4
F 00000444 FFFFFBBB 0 4
F 00000040 FFFFFFBF 0 8
F 00000248 FFFFFDB7 0 8
F 0000044C FFFFFBB3 0 8
# Invalidate, cached lines come from the bus again
I 00000000 00000000 0 0
F 00000104 FFFFFEFB 0 4
F 00000100 FFFFFEFF 0 0
F 00000044 FFFFFFBB 0 4
# Error region, nothing is cached
F 0000F010 00000000 1 1
F 0000F010 00000000 1 1
F 0000F01C 00000000 1 1
F 00000104 FFFFFEFB 0 0
# Mixed stream of hits and misses
F 00000580 FFFFFA7F 0 4
F 00000584 FFFFFA7B 0 0
F 00000588 FFFFFA77 0 0
F 0000058C FFFFFA73 0 0
F 00000590 FFFFFA6F 0 4
F 00000594 FFFFFA6B 0 0
F 0000010C FFFFFEF3 0 0
F 000005A0 FFFFFA5F 0 4
F 00000580 FFFFFA7F 0 0

/* vlog.f */
icache_cfg_pkg.sv
icache_bus_pkg.sv
icache_setup.sv
icache_memory.sv
icache_hit.sv
icache_biu_ctrl.sv
icache_top.sv
tb_wb_mem.sv
tb_icache.sv

/* Makefile */
# Verilator simulation of the instruction cache testbench
# Variables can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then echo "Result: pass"; \
	else echo "Result: fail, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_icache.sv */
// Instruction cache testbench top
// Clock, reset, DUT and Wishbone slave model
// Fetch and invalidate sequence read from the test data file
// Response monitor with bus transfer tracking and checks

`timescale 1ns/1ps

module tb_icache
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
();

  localparam int         TIMEOUT_CYCLES = 200;     // Per wait loop
  localparam logic [3:0] BEATS_EITHER   = 4'h8;    // No transfer or a full line
  localparam string      DATA_FILE      = "icache_testdata.txt";

  // One line of the data file
  typedef struct packed {
    logic [7:0]      op;                           // F or I
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] word;
    logic            err;
    logic [3:0]      beats;
  } test_op_t;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  fetch_req_t fetch_req;
  logic       stall;
  fetch_rsp_t fetch_rsp;
  logic       cache_flush;
  wb_m2s_t    wb_m2s;
  wb_s2m_t    wb_s2m;

  test_op_t        ops_q      [$];
  test_op_t        pend_q     [$];                 // Accepted fetches awaiting a response
  logic [XLEN-1:0] beat_adr_q [$];                 // Transfers since last response

  always #10 clk_i = ~clk_i;                       // 20 ns period

  icache_top i_icache_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_req_i   (fetch_req),
    .stall_o       (stall),
    .fetch_rsp_o   (fetch_rsp),
    .cache_flush_i (cache_flush),
    .wb_o          (wb_m2s),
    .wb_i          (wb_s2m)
  );

  tb_wb_mem i_wb_mem (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .wb_i   (wb_m2s),
    .wb_o   (wb_s2m)
  );

  // --------------------------------------------------------------------------
  // Failure reporting and checks
  // --------------------------------------------------------------------------
  task automatic stop_on_failure();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    stop_on_failure();
  endtask

  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("ERROR: %s got 0x%08h expected 0x%08h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic load_ops();
    int              fd;
    int              n;
    string           text;
    logic [7:0]      code;
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] word;
    logic            err;
    logic [3:0]      beats;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) report_failure("Could not open the test data file");
    while (!$feof(fd)) begin
      text = "";
      n    = $fgets(text, fd);
      if (n > 1 && text.getc(0) != "#") begin      // Skip comments and blank lines
        n = $sscanf(text, "%c %h %h %h %h", code, adr, word, err, beats);
        if (n != 5 || (code != "F" && code != "I")) begin
          report_failure($sformatf("Malformed line in test data file: %s", text));
        end
        ops_q.push_back('{code, adr, word, err, beats});
      end
    end
    $fclose(fd);
  endtask

  // Expected word is don't care on a bus error
  task automatic check_response(input test_op_t exp);
    logic [XLEN-1:0] base;
    int              beats;
    base  = {exp.adr[XLEN-1:BLK_OFFS_BITS], {BLK_OFFS_BITS{1'b0}}};
    beats = beat_adr_q.size();
    check_value("fetch_rsp_o.pc", fetch_rsp.pc, exp.adr);
    check_value("fetch_rsp_o.error", XLEN'(fetch_rsp.error), XLEN'(exp.err));
    if (!exp.err) check_value("fetch_rsp_o.word", fetch_rsp.word, exp.word);
    if (exp.beats != BEATS_EITHER) begin
      check_value("wb transfer count", beats, XLEN'(exp.beats));
    end else if (beats != 0 && beats != BURST_LEN) begin
      report_failure($sformatf("Fetch at 0x%08h made %0d bus transfers, not zero or a line",
                               exp.adr, beats));
    end
    for (int i = 0; i < beats; i++) begin
      check_value("wb_o.adr", beat_adr_q[i], base + XLEN'(i * 4));  // Upward from base
    end
    beat_adr_q.delete();
  endtask

  // --------------------------------------------------------------------------
  // Monitor, sampled on the rising edge
  // --------------------------------------------------------------------------
  // Response first since a transfer on this edge belongs to the next fetch
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (fetch_rsp.valid) begin
        if (pend_q.size() == 0) report_failure("Response arrived with no fetch outstanding");
        else check_response(pend_q.pop_front());
      end
      if (wb_m2s.cyc && wb_m2s.stb && (wb_s2m.ack || wb_s2m.err)) begin
        check_value("wb_o.we", XLEN'(wb_m2s.we), '0);
        check_value("wb_o.sel", XLEN'(wb_m2s.sel), XLEN'(4'hf));
        beat_adr_q.push_back(wb_m2s.adr);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Driver, falling edge
  // --------------------------------------------------------------------------
  task automatic issue_fetch(input test_op_t op);
    int   cycles;
    logic stalled;
    cycles          = 0;
    fetch_req.valid = 1'b1;
    fetch_req.adr   = op.adr;
    do begin
      stalled = stall;                             // Value at the coming rising edge
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        report_failure($sformatf("Fetch at 0x%08h was never accepted", op.adr));
      end
    end while (stalled);
    pend_q.push_back(op);
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (pend_q.size() != 0) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) report_failure("Outstanding fetches got no response");
    end
  endtask

  task automatic wait_stall(input logic level);
    int cycles;
    cycles = 0;
    while (stall !== level) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        report_failure($sformatf("stall_o never went to %0b during invalidate", level));
      end
    end
  endtask

  // Idle front end lets the invalidate run right after the pulse
  task automatic run_flush();
    wait_drained();
    cache_flush = 1'b1;
    @(negedge clk_i);
    cache_flush = 1'b0;
    wait_stall(1'b1);                              // FLUSHING cycle
    wait_stall(1'b0);
  endtask

  initial begin
    fetch_req   = '0;
    cache_flush = 1'b0;
    rst_ni      = 1'b0;
    load_ops();
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    check_value("stall_o", XLEN'(stall), '0);
    check_value("fetch_rsp_o.valid", XLEN'(fetch_rsp.valid), '0);
    check_value("wb_o.cyc", XLEN'(wb_m2s.cyc), '0);
    check_value("wb_o.stb", XLEN'(wb_m2s.stb), '0);
    foreach (ops_q[i]) begin
      if (ops_q[i].op == "I") begin
        fetch_req.valid = 1'b0;
        run_flush();
      end else begin
        issue_fetch(ops_q[i]);                     // Back to back
      end
    end
    fetch_req.valid = 1'b0;
    wait_drained();
    check_value("wb transfers after last response", beat_adr_q.size(), '0);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* tb_wb_mem.sv */
// Wishbone classic slave model for the instruction cache testbench
// Read data is the bitwise inverse of the word address
// Error region and LCG driven ack delay of 0 to 3 cycles

`timescale 1ns/1ps

module tb_wb_mem
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  wb_m2s_t wb_i,        // From the cache
  output wb_s2m_t wb_o
);

  localparam logic [XLEN-1:0] ERR_FIRST = 32'h0000_F000;
  localparam logic [XLEN-1:0] ERR_LAST  = 32'h0000_FFFF;
  localparam logic [31:0]     LCG_SEED  = 32'h7b5d;

  logic [31:0] lcg_q;
  logic        busy_q;         // Delay of the current beat already drawn
  logic [1:0]  wait_q;         // Idle cycles left before the answer

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic in_err_region(input logic [XLEN-1:0] adr);
    return (adr >= ERR_FIRST) && (adr <= ERR_LAST);
  endfunction

  // Answers change on the falling edge, the cache samples on the rising edge
  always @(negedge clk_i or negedge rst_ni) begin
    logic [1:0] delay;
    if (!rst_ni) begin
      wb_o   <= '0;
      busy_q <= 1'b0;
      wait_q <= '0;
      lcg_q  <= LCG_SEED;
    end else if (wb_o.ack || wb_o.err) begin
      wb_o   <= '0;                              // Beat done on the last rising edge
      busy_q <= 1'b0;
    end else if (wb_i.cyc && wb_i.stb) begin
      delay = busy_q ? wait_q : lcg_q[17:16];    // Fresh draw for a new beat
      if (!busy_q) begin
        lcg_q  <= lcg_next(lcg_q);
        busy_q <= 1'b1;
      end
      if (delay == 2'd0) begin
        wb_o.ack <= !in_err_region(wb_i.adr);
        wb_o.err <= in_err_region(wb_i.adr);
        wb_o.dat <= ~wb_i.adr;
      end else begin
        wait_q <= delay - 2'd1;
      end
    end
  end

endmodule

/* icache_top.sv */
// Instruction cache top level
// Setup stage, memory arrays, hit stage and Wishbone line fetch controller

`timescale 1ns/1ps

module icache_top
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  fetch_req_t fetch_req_i,
  output logic       stall_o,
  output fetch_rsp_t fetch_rsp_o,
  input  logic       cache_flush_i,
  output wb_m2s_t    wb_o,
  input  wb_s2m_t    wb_i
);

  fetch_req_t       setup_req;
  idx_t             rd_idx;
  tag_t             hit_tag;
  idx_t             hit_idx;
  logic             cache_hit;
  line_t            cache_line;
  logic             invalidate;
  logic             fill_req, fill_done, fill_err;
  logic [XLEN-1:0]  fill_adr;
  line_t            fill_line;

  icache_setup i_setup (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (fetch_req_i),
    .stall_i  (stall_o),
    .req_o    (setup_req),
    .rd_idx_o (rd_idx)
  );

  // Only an error-free refill is written
  icache_memory i_memory (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_idx_i     (rd_idx),
    .cmp_tag_i    (hit_tag),
    .wr_idx_i     (hit_idx),
    .fill_we_i    (fill_done & ~fill_err),
    .fill_line_i  (fill_line),
    .invalidate_i (invalidate),
    .hit_o        (cache_hit),
    .line_o       (cache_line)
  );

  icache_hit i_hit (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (setup_req),
    .hit_i         (cache_hit),
    .line_i        (cache_line),
    .cache_flush_i (cache_flush_i),
    .stall_o       (stall_o),
    .tag_o         (hit_tag),
    .idx_o         (hit_idx),
    .invalidate_o  (invalidate),
    .fill_req_o    (fill_req),
    .fill_adr_o    (fill_adr),
    .fill_done_i   (fill_done),
    .fill_err_i    (fill_err),
    .fill_line_i   (fill_line),
    .rsp_o         (fetch_rsp_o)
  );

  icache_biu_ctrl i_biu_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fill_req_i  (fill_req),
    .fill_adr_i  (fill_adr),
    .fill_done_o (fill_done),
    .fill_err_o  (fill_err),
    .fill_line_o (fill_line),
    .wb_o        (wb_o),
    .wb_i        (wb_i)
  );

endmodule

/* icache_biu_ctrl.sv */
// Wishbone classic line fetch controller
// Four single-word reads from the line base address
// Beat counter and line assembly buffer
// Abort on bus error and fill-done pulse with error flag

`timescale 1ns/1ps

module icache_biu_ctrl
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            fill_req_i,
  input  logic [XLEN-1:0] fill_adr_i,    // Line base
  output logic            fill_done_o,   // One cycle after last completion
  output logic            fill_err_o,
  output line_t           fill_line_o,
  output wb_m2s_t         wb_o,
  input  wb_s2m_t         wb_i
);

  biu_state_e                      state_q;
  logic [BURST_BITS-1:0]           beat_q;
  logic [XLEN-BLK_OFFS_BITS-1:0]   line_adr_q;
  line_t                           line_q;
  logic                            done_q, err_q;
  logic                            last_beat;

  assign last_beat = (beat_q == BURST_BITS'(BURST_LEN - 1));

  // --------------------------------------------------------------------------
  // Burst FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      beat_q  <= '0;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;                          // Pulse
      case (state_q)
        IDLE: if (fill_req_i) begin
          state_q <= BURST;
          beat_q  <= '0;
          err_q   <= 1'b0;
        end
        BURST: if (wb_i.err) begin
          state_q <= IDLE;                     // Abort drops the rest of the line
          done_q  <= 1'b1;
          err_q   <= 1'b1;
        end else if (wb_i.ack) begin
          beat_q <= beat_q + 1'b1;
          if (last_beat) begin
            state_q <= IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Line address and assembled data
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && fill_req_i) begin
      line_adr_q <= fill_adr_i[XLEN-1:BLK_OFFS_BITS];
    end
    if (state_q == BURST && wb_i.ack && !wb_i.err) begin
      line_q[beat_q*XLEN +: XLEN] <= wb_i.dat;  // Slot by beat
    end
  end

  // --------------------------------------------------------------------------
  // Bus side
  // --------------------------------------------------------------------------
  assign wb_o.cyc = (state_q == BURST);
  assign wb_o.stb = (state_q == BURST);
  assign wb_o.we  = 1'b0;                      // Read only
  assign wb_o.sel = '1;
  assign wb_o.adr = {line_adr_q, beat_q, {WORD_OFFS_BITS{1'b0}}};

  assign fill_done_o = done_q;
  assign fill_err_o  = err_q;
  assign fill_line_o = line_q;

  a_stb_in_cyc : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_o.stb |-> wb_o.cyc);

endmodule

/* icache_hit.sv */
// Hit stage and front-end state machine
// Hit/miss decision and word select from the line
// Miss handling with line refill request and stall
// Response register, pending invalidate and flush sequencing

`timescale 1ns/1ps

module icache_hit
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  fetch_req_t      req_i,          // Held request from setup
  input  logic            hit_i,
  input  line_t           line_i,
  input  logic            cache_flush_i,  // Invalidate request pulse
  output logic            stall_o,
  output tag_t            tag_o,          // Compare and fill tag
  output idx_t            idx_o,          // Fill set
  output logic            invalidate_o,
  output logic            fill_req_o,
  output logic [XLEN-1:0] fill_adr_o,     // Line base
  input  logic            fill_done_i,
  input  logic            fill_err_i,
  input  line_t           fill_line_i,
  output fetch_rsp_t      rsp_o
);

  hit_state_e             state_q, state_d;
  logic                   flush_pend_q;
  logic [XLEN-1:0]        miss_adr_q;     // Address of the fetch being refilled
  logic [BURST_BITS-1:0]  req_word, miss_word;
  logic                   hit_take, fill_take;

  logic                   rsp_valid_q;
  logic                   rsp_err_q;
  logic [XLEN-1:0]        rsp_pc_q;
  logic [XLEN-1:0]        rsp_word_q;

  assign req_word  = req_i.adr[BLK_OFFS_BITS-1:WORD_OFFS_BITS];
  assign miss_word = miss_adr_q[BLK_OFFS_BITS-1:WORD_OFFS_BITS];

  assign hit_take  = (state_q == ARMED) && req_i.valid && hit_i;
  assign fill_take = (state_q == WAIT_FILL) && fill_done_i;

  // --------------------------------------------------------------------------
  // Front-end FSM
  // --------------------------------------------------------------------------
  always_comb begin
    state_d    = state_q;
    fill_req_o = 1'b0;
    case (state_q)
      ARMED: begin
        if (req_i.valid) begin
          if (!hit_i) begin
            fill_req_o = 1'b1;                 // Miss starts a line fetch
            state_d    = WAIT_FILL;
          end
        end else if (flush_pend_q) begin
          state_d = FLUSHING;                  // Idle front end may invalidate
        end
      end
      WAIT_FILL: if (fill_done_i) state_d = ARMED;
      FLUSHING:  state_d = ARMED;              // Single cycle
      default:   state_d = ARMED;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ARMED;
      flush_pend_q <= 1'b0;
      rsp_valid_q  <= 1'b0;
    end else begin
      state_q      <= state_d;
      flush_pend_q <= cache_flush_i | (flush_pend_q & (state_q != FLUSHING));
      rsp_valid_q  <= hit_take | fill_take;
    end
  end

  // Miss address and response payload
  always_ff @(posedge clk_i) begin
    if (fill_req_o) begin
      miss_adr_q <= req_i.adr;
    end
    if (hit_take) begin
      rsp_err_q  <= 1'b0;
      rsp_pc_q   <= req_i.adr;
      rsp_word_q <= line_i[req_word*XLEN +: XLEN];
    end else if (fill_take) begin
      rsp_err_q  <= fill_err_i;                // Word is don't care on error
      rsp_pc_q   <= miss_adr_q;
      rsp_word_q <= fill_line_i[miss_word*XLEN +: XLEN];
    end
  end

  // --------------------------------------------------------------------------
  // Outputs
  // --------------------------------------------------------------------------
  assign stall_o      = (state_q != ARMED);
  assign invalidate_o = (state_q == FLUSHING);

  // Refill owns the tag while waiting for the line
  assign tag_o = (state_q == WAIT_FILL) ? miss_adr_q[XLEN-1 -: TAG_BITS]
                                        : req_i.adr[XLEN-1 -: TAG_BITS];
  assign idx_o = miss_adr_q[BLK_OFFS_BITS +: IDX_BITS];

  assign fill_adr_o = {req_i.adr[XLEN-1:BLK_OFFS_BITS], {BLK_OFFS_BITS{1'b0}}};

  assign rsp_o.valid = rsp_valid_q;
  assign rsp_o.error = rsp_err_q;
  assign rsp_o.pc    = rsp_pc_q;
  assign rsp_o.word  = rsp_word_q;

  // Refill starts only from ARMED
  a_fill_from_armed : assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_req_o |-> (state_q == ARMED));

endmodule

/* icache_memory.sv */
// Instruction cache memory block
// Per-way tag, valid and data arrays with registered read index
// Tag compare and hit-way line select
// Line fill into an LFSR chosen victim way, whole-cache invalidate

`timescale 1ns/1ps

module icache_memory
  import icache_cfg_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  idx_t  rd_idx_i,      // Set to read, from setup stage
  input  tag_t  cmp_tag_i,     // Compare tag, also the fill tag
  input  idx_t  wr_idx_i,      // Fill set
  input  logic  fill_we_i,
  input  line_t fill_line_i,
  input  logic  invalidate_i,  // Clear all valid bits
  output logic  hit_o,
  output line_t line_o
);

  tag_t                  tag_mem  [WAYS][SETS];
  line_t                 data_mem [WAYS][SETS];
  way_sel_t [SETS-1:0]   valid_q;              // Per set, one bit per way

  idx_t                  rd_idx_q;
  way_sel_t              way_hit;
  way_sel_t              victim;
  logic [LFSR_BITS-1:0]  lfsr_q;

  // --------------------------------------------------------------------------
  // Victim way selection
  // --------------------------------------------------------------------------
  // XNOR feedback, all-zero reset state is legal
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= '0;
    end else if (!fill_we_i) begin
      lfsr_q <= {lfsr_q[LFSR_BITS-2:0], lfsr_q[6] ~^ lfsr_q[5]};
    end
  end

  assign victim = way_sel_t'(1) << lfsr_q[$clog2(WAYS)-1:0];

  // --------------------------------------------------------------------------
  // Arrays
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_idx_q <= '0;
    end else begin
      rd_idx_q <= rd_idx_i;                    // Synchronous read address
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (invalidate_i) begin
      valid_q <= '0;                           // Whole cache in one cycle
    end else if (fill_we_i) begin
      valid_q[wr_idx_i] <= valid_q[wr_idx_i] | victim;
    end
  end

  // Tag and line contents
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < WAYS; w++) begin
      if (fill_we_i && victim[w]) begin
        tag_mem[w][wr_idx_i]  <= cmp_tag_i;
        data_mem[w][wr_idx_i] <= fill_line_i;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Compare
  // --------------------------------------------------------------------------
  // Arrays read at the registered index, a fill is seen the next cycle
  always_comb begin
    way_hit = '0;
    line_o  = '0;
    for (int w = 0; w < WAYS; w++) begin
      way_hit[w] = valid_q[rd_idx_q][w] && (tag_mem[w][rd_idx_q] == cmp_tag_i);
      if (way_hit[w]) begin
        line_o = line_o | data_mem[w][rd_idx_q];   // Single hit way, OR is a mux
      end
    end
  end

  assign hit_o = |way_hit;

  // A fill only targets a missing line, so a tag lives in one way at most
  a_one_way_hit : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(way_hit));

endmodule

/* icache_setup.sv */
// Address setup stage
// Request register, held while the front end stalls
// Read index for the tag, valid and data arrays

`timescale 1ns/1ps

module icache_setup
  import icache_cfg_pkg::*;
  import icache_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  fetch_req_t req_i,      // From CPU
  input  logic       stall_i,
  output fetch_req_t req_o,      // Held request, to hit stage
  output idx_t       rd_idx_o    // To memory
);

  logic             req_valid_q;
  logic [XLEN-1:0]  req_adr_q;

  // Valid bit, cleared by reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else if (!stall_i) begin
      req_valid_q <= req_i.valid;
    end
  end

  // Fetch address
  always_ff @(posedge clk_i) begin
    if (!stall_i && req_i.valid) begin
      req_adr_q <= req_i.adr;
    end
  end

  assign req_o.valid = req_valid_q;
  assign req_o.adr   = req_adr_q;

  // Re-read the held set while stalled, picks up a completed fill
  assign rd_idx_o = stall_i ? req_adr_q[BLK_OFFS_BITS +: IDX_BITS]
                            : req_i.adr[BLK_OFFS_BITS +: IDX_BITS];

  // Held request must not move under a stall
  a_hold_on_stall : assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_i |=> $stable(req_o.valid) && (!req_o.valid || $stable(req_o.adr)));

endmodule

/* icache_bus_pkg.sv */
// Instruction cache bus package
// CPU fetch request and response structs
// Wishbone classic master and slave side structs
// Front-end and bus controller state encodings

package icache_bus_pkg;

  typedef struct packed {
    logic                             valid;
    logic [icache_cfg_pkg::XLEN-1:0]  adr;       // Physical fetch address
  } fetch_req_t;

  typedef struct packed {
    logic                             valid;     // One pulse per fetch
    logic                             error;     // Bus error on refill
    logic [icache_cfg_pkg::XLEN-1:0]  pc;
    logic [icache_cfg_pkg::XLEN-1:0]  word;
  } fetch_rsp_t;

  // Wishbone classic, master to slave
  typedef struct packed {
    logic                               cyc;
    logic                               stb;
    logic                               we;
    logic [icache_cfg_pkg::XLEN/8-1:0]  sel;
    logic [icache_cfg_pkg::XLEN-1:0]    adr;
  } wb_m2s_t;

  // Wishbone classic, slave to master
  typedef struct packed {
    logic                             ack;
    logic                             err;
    logic [icache_cfg_pkg::XLEN-1:0]  dat;
  } wb_s2m_t;

  typedef enum logic [1:0] {ARMED, WAIT_FILL, FLUSHING} hit_state_e;
  typedef enum logic       {IDLE, BURST}                biu_state_e;

endpackage

/* icache_cfg_pkg.sv */
// Instruction cache configuration package
// Fixed cache geometry (capacity, line size, ways, sets)
// Derived address field widths and burst sizing
// Index, tag, line and way-select types

package icache_cfg_pkg;

  // --------------------------------------------------------------------------
  // Base geometry
  // --------------------------------------------------------------------------
  localparam int XLEN        = 32;                             // Word and address width
  localparam int CACHE_BYTES = 1024;                           // Total capacity
  localparam int BLOCK_BYTES = 16;                             // One cache line
  localparam int WAYS        = 2;                              // Associativity
  localparam int SETS        = CACHE_BYTES / BLOCK_BYTES / WAYS;

  // --------------------------------------------------------------------------
  // Address split: | tag | index | word | byte |
  // --------------------------------------------------------------------------
  localparam int WORD_OFFS_BITS = $clog2(XLEN / 8);            // Byte within word
  localparam int BLK_OFFS_BITS  = $clog2(BLOCK_BYTES);         // Byte within line
  localparam int IDX_BITS       = $clog2(SETS);
  localparam int TAG_BITS       = XLEN - IDX_BITS - BLK_OFFS_BITS;

  // Line refill as single-word bus transfers
  localparam int BURST_LEN  = BLOCK_BYTES / (XLEN / 8);
  localparam int BURST_BITS = $clog2(BURST_LEN);

  // Victim selection generator
  localparam int LFSR_BITS = 7;

  typedef logic [IDX_BITS-1:0]        idx_t;
  typedef logic [TAG_BITS-1:0]        tag_t;
  typedef logic [BLOCK_BYTES*8-1:0]   line_t;                  // Word 0 in the low bits
  typedef logic [WAYS-1:0]            way_sel_t;               // One-hot

endpackage
